// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := uart_rx_array_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/uart_rx_array_sva.sv ====
`timescale 1ns/1ps

module uart_rx_array_sva import uart_cfg_pkg::*; (
	input logic                    clk,
	input logic                    reset,
	input logic                    strobe,   // sampling strobe, tied low in the collector
	input logic [num_channels-1:0] valid,    // frame_valid as seen by the bound module
	input logic [num_channels-1:0] ack,
	input logic                    psel,
	input logic                    penable,
	input logic                    pslverr
);

	strobe_single_cycle: assert property (@(posedge clk) disable iff (reset)
		strobe |=> !strobe)
		else $error("sampling strobe stayed high for two cycles");

	ack_only_valid: assert property (@(posedge clk) disable iff (reset)
		(ack & ~valid) == '0)
		else $error("ack sent to a channel without a valid frame");

	ack_one_hot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ack))
		else $error("ack went to more than one channel");

	// a valid frame may only leave after its ack
	valid_held: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (($past(valid) & ~$past(ack)) & ~valid) == '0)
		else $error("frame_valid dropped without an ack");

	slverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable)
		else $error("pslverr outside an apb access phase");

endmodule

bind uart_rx_channel uart_rx_array_sva u_channel_sva (
	.clk    (clk),
	.reset  (reset),
	.strobe (strobe),
	.valid  (num_channels'(frame_valid)),  // a single channel fills bit 0 only
	.ack    (num_channels'(ack)),
	.psel   (1'b0),
	.penable(1'b0),
	.pslverr(1'b0)
);

bind rx_collector uart_rx_array_sva u_collector_sva (
	.clk    (clk),
	.reset  (reset),
	.strobe (1'b0),
	.valid  (frame_valid),
	.ack    (ack),
	.psel   (apb_req.psel),
	.penable(apb_req.penable),
	.pslverr(apb_rsp.pslverr)
);

// ==== bench/uart_rx_array_tb.sv ====
`timescale 1ns/1ps

module uart_rx_array_tb import uart_cfg_pkg::*; import apb_pkg::*; ();

	localparam int clk_period_ns = 10;
	localparam int total_frames = 35;   // every frame the serial drivers put on a line
	localparam int watchdog_ns = total_frames * 10 * clocks_per_bit * clk_period_ns * 3;
	localparam int poll_limit = 200;    // empty status polls allowed before giving up

	logic                    clk;
	logic                    reset;
	logic [num_channels-1:0] rx;
	apb_req_t                apb_req;
	apb_rsp_t                apb_rsp;

	integer     seed;                         // shared random state
	int         frames_read;                  // frames popped through the data register
	logic [8:0] exp_q [num_channels][$];      // expected {data, framing_err} per channel

	uart_rx_array u_uart_rx_array (
		.clk    (clk),
		.reset  (reset),
		.rx     (rx),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	always #(clk_period_ns / 2) clk = ~clk;

	task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("%s at %0t ns", what, $time);
		$display("*** FAILED ***");
		$fatal(1, "run stopped early");
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b1;  // setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;  // access phase, the write lands on the next edge
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge clk);          // response is settled halfway through the access cycle
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic drive_bit(input int ch, input logic value);
		rx[ch] = value;
		repeat (clocks_per_bit) @(posedge clk);
		#1;
	endtask

	// 8n1 frame, lsb first, the line is left idle high afterwards
	task automatic send_frame(input int ch, input logic [7:0] data, input logic stop_bit,
			input bit expect_it);
		if (expect_it) exp_q[ch].push_back({data, ~stop_bit});
		@(posedge clk);
		#1;
		drive_bit(ch, 1'b0);
		for (int b = 0; b < data_bits; b++) begin
			drive_bit(ch, data[b]);
		end
		drive_bit(ch, stop_bit);
		rx[ch] = 1'b1;  // a low stop bit still has to return to idle
	endtask

	task automatic chan_stream(input int ch, input int n);
		int gap;
		for (int k = 0; k < n; k++) begin
			gap = $unsigned($random(seed)) % 40;  // random offset so channels overlap unevenly
			repeat (gap) @(posedge clk);
			send_frame(ch, 8'($random(seed)), 1'b1, 1'b1);
		end
	endtask

	task automatic read_frame();
		logic [31:0] d;
		logic        e;
		rx_frame_t   f;
		apb_read(reg_data, d, e);
		check(32'(e), 0, "pslverr on a data read");
		check(d[31:11], 0, "unused bits of a data read");
		f = rx_frame_t'(d[10:0]);
		check(32'(exp_q[f.chan].size() > 0), 1, "frame arrived with nothing expected");
		check({f.data, f.framing_err}, exp_q[f.chan].pop_front(),
			$sformatf("data and framing_err on channel %0d", f.chan));
		frames_read++;
	endtask

	// pops frames as they show up until the running total reaches target
	task automatic drain(input int target);
		int          polls;
		logic [31:0] d;
		logic        e;
		polls = 0;
		while (frames_read < target) begin
			apb_read(reg_status, d, e);
			if (d[3:0] != 0) begin
				read_frame();
				polls = 0;
			end else begin
				polls++;
				if (polls > poll_limit) timeout_fail("no frame reached the fifo in time");
			end
		end
	endtask

	task automatic wait_count(input int n);
		int          polls;
		logic [31:0] d;
		logic        e;
		polls = 0;
		apb_read(reg_status, d, e);
		while (int'(d[3:0]) < n) begin
			polls++;
			if (polls > poll_limit) timeout_fail("fifo count never reached its target");
			apb_read(reg_status, d, e);
		end
	endtask

	initial begin
		#(watchdog_ns);
		timeout_fail("watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] d;
		logic        e;
		int          ch;
		clk = 1'b0;
		reset = 1'b1;
		rx = '1;          // idle lines
		apb_req = '0;
		seed = 32'hf1d1;
		frames_read = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int k = 0; k < 6; k++) begin  // one frame at a time on a random channel
			ch = $unsigned($random(seed)) % num_channels;
			send_frame(ch, 8'($random(seed)), 1'b1, 1'b1);
			drain(frames_read + 1);
		end

		fork  // all channels at once while the reader drains
			chan_stream(0, 4);
			chan_stream(1, 4);
			chan_stream(2, 4);
			chan_stream(3, 4);
			drain(frames_read + 16);
		join
		apb_read(reg_status, d, e);        // every line is idle again so nothing may be left over
		check(d[5:0], 6'b100000, "status after all streamed frames were read");

		send_frame(2, 8'($random(seed)), 1'b0, 1'b1);  // stop bit held low
		drain(frames_read + 1);

		@(posedge clk);
		#1;
		rx[3] = 1'b0;                      // four cycle low pulse is shorter than half a bit
		repeat (4) @(posedge clk);
		#1;
		rx[3] = 1'b1;
		repeat (12 * clocks_per_bit) @(posedge clk);
		apb_read(reg_status, d, e);
		check(d[5:0], 6'b100000, "status after a glitch");

		apb_write(reg_ctrl, 32'hd);        // channel 1 off
		apb_read(reg_ctrl, d, e);
		check(d, 32'hd, "ctrl read back");
		send_frame(1, 8'h5a, 1'b1, 1'b0);
		repeat (4 * clocks_per_bit) @(posedge clk);
		apb_read(reg_status, d, e);
		check(d[5:0], 6'b100000, "status with channel 1 disabled");
		apb_write(reg_ctrl, 32'hf);
		send_frame(1, 8'($random(seed)), 1'b1, 1'b1);
		drain(frames_read + 1);

		for (int k = 0; k < 10; k++) begin  // the last two find the fifo full
			send_frame(0, 8'($random(seed)), 1'b1, k < fifo_depth);
		end
		wait_count(fifo_depth);
		apb_read(reg_status, d, e);
		check(d[5:0], 6'b011000, "status after overflow");
		drain(frames_read + fifo_depth);
		apb_read(reg_data, d, e);
		check(32'(e), 1, "pslverr on an empty read");
		check(d, 0, "data of an empty read");
		apb_write(reg_status, 32'h0);      // clears the sticky overflow
		apb_read(reg_status, d, e);
		check(d[5:0], 6'b100000, "status after clearing overflow");

		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== compile.f ====
src/uart_cfg_pkg.sv
src/apb_pkg.sv
src/rx_line_sync.sv
src/sampling_strobe_generator.sv
src/uart_rx_channel.sv
src/rx_collector.sv
src/uart_rx_array.sv
bench/uart_rx_array_sva.sv
bench/uart_rx_array_tb.sv

// ==== src/apb_pkg.sv ====
package apb_pkg;

	localparam int apb_addr_w = 4;                 // register window covers 0x0 to 0xf
	localparam int apb_data_w = 32;                // standard apb data width
	localparam int fifo_depth = 8;                 // frames buffered before overflow
	localparam int fifo_cnt_w = 4;                 // holds counts 0 up to fifo_depth
	localparam int fifo_ptr_w = $clog2(fifo_depth); // circular read and write pointer width

	// request side of the bus as driven by the master
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [apb_addr_w-1:0] paddr;
		logic [apb_data_w-1:0] pwdata;
	} apb_req_t;

	// response side, the slave has no wait states so there is no pready
	typedef struct packed {
		logic [apb_data_w-1:0] prdata;
		logic                  pslverr;
	} apb_rsp_t;

	// register map of the collector
	typedef enum logic [apb_addr_w-1:0] {
		reg_status = 4'h0, // count, overflow and empty flags
		reg_data   = 4'h4, // frame read port that pops the fifo
		reg_ctrl   = 4'h8  // channel enable mask
	} reg_addr_t;

endpackage

// ==== src/rx_collector.sv ====
`timescale 1ns/1ps

module rx_collector import uart_cfg_pkg::*; import apb_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  rx_frame_t               frame [num_channels],  // frames offered by each channel
	input  logic [num_channels-1:0] frame_valid,
	output logic [num_channels-1:0] ack,                   // one hot grant back to the channels
	input  apb_req_t                apb_req,
	output apb_rsp_t                apb_rsp,
	output logic [num_channels-1:0] enable                 // channel enable mask to the sync stage
);

	rx_frame_t               mem [fifo_depth];  // circular frame storage
	logic [fifo_ptr_w-1:0]   wr_ptr;
	logic [fifo_ptr_w-1:0]   rd_ptr;
	logic [fifo_cnt_w-1:0]   count;             // frames currently stored
	logic                    overflow;          // sticky, a frame was dropped on a full fifo
	logic                    full;
	logic                    empty;
	logic [chan_id_w-1:0]    last_grant;        // search starts just after this channel
	logic [chan_id_w-1:0]    grant_id;
	logic                    grant_any;
	logic [chan_id_w-1:0]    idx;
	logic                    access;            // apb access phase
	logic                    push;
	logic                    pop;
	reg_addr_t               addr;

	assign full  = (count == fifo_cnt_w'(fifo_depth));
	assign empty = (count == '0);

	// round robin search over all channels starting after the last one granted
	always_comb begin
		grant_any = 1'b0;
		grant_id  = last_grant;
		idx       = '0;
		for (int i = 1; i <= num_channels; i++) begin
			idx = chan_id_w'((int'(last_grant) + i) % num_channels);
			if (frame_valid[idx] && !grant_any) begin
				grant_any = 1'b1;
				grant_id  = idx;
			end
		end
		ack = '0;
		if (grant_any) ack[grant_id] = 1'b1;  // at most one channel per cycle
	end

	assign access = apb_req.psel && apb_req.penable;
	assign addr   = reg_addr_t'(apb_req.paddr);
	assign push   = grant_any && !full;            // a grant on a full fifo is acked and dropped
	assign pop    = access && !apb_req.pwrite && (addr == reg_data) && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow   <= 1'b0;
			last_grant <= chan_id_w'(num_channels - 1);  // channel 0 wins the first search
			enable     <= '1;
		end else begin
			if (grant_any) last_grant <= grant_id;
			if (push) wr_ptr <= wr_ptr + fifo_ptr_w'(1);
			if (pop) rd_ptr <= rd_ptr + fifo_ptr_w'(1);
			if (push && !pop) count <= count + fifo_cnt_w'(1);
			else if (pop && !push) count <= count - fifo_cnt_w'(1);
			if (access && apb_req.pwrite && addr == reg_status) overflow <= 1'b0;
			if (grant_any && full) overflow <= 1'b1;      // a new drop outranks a clear in the same cycle
			if (access && apb_req.pwrite && addr == reg_ctrl) enable <= apb_req.pwdata[num_channels-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= frame[grant_id];  // written in the ack cycle
	end

	// read data is decoded combinationally and valid during the access phase
	always_comb begin
		apb_rsp.prdata  = '0;
		apb_rsp.pslverr = 1'b0;
		case (addr)
			reg_status: apb_rsp.prdata = apb_data_w'({empty, overflow, count});
			reg_data: begin
				if (empty) apb_rsp.pslverr = access && !apb_req.pwrite;  // nothing to pop
				else apb_rsp.prdata = apb_data_w'(mem[rd_ptr]);
			end
			reg_ctrl:   apb_rsp.prdata = apb_data_w'(enable);
			default:    apb_rsp.pslverr = access;  // unmapped address
		endcase
	end

endmodule

// ==== src/rx_line_sync.sv ====
`timescale 1ns/1ps

module rx_line_sync import uart_cfg_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [num_channels-1:0] rx,         // raw asynchronous serial lines
	input  logic [num_channels-1:0] enable,     // channel enable mask from ctrl
	output logic [num_channels-1:0] line,       // synchronized and masked lines
	output logic [num_channels-1:0] start_edge  // one cycle pulse on each falling edge
);

	logic [num_channels-1:0] meta_q;  // first synchronizer stage
	logic [num_channels-1:0] sync_q;  // second synchronizer stage
	logic [num_channels-1:0] line_q;  // masked line one cycle back for edge detect

	always_ff @(posedge clk) begin
		if (reset) begin
			meta_q <= '1;           // lines idle high so no false start after reset
			sync_q <= '1;
			line_q <= '1;
		end else begin
			meta_q <= rx;
			sync_q <= meta_q;
			line_q <= line;         // remembers the masked value so disabling cannot look like a start
		end
	end

	assign line = sync_q | ~enable;        // a disabled channel sees a permanently idle line

	assign start_edge = line_q & ~line;    // high in the first cycle the line reads low

endmodule

// ==== src/sampling_strobe_generator.sv ====
`timescale 1ns/1ps

module sampling_strobe_generator import uart_cfg_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic start_detected,  // start edge seen while the receiver is idle
	output logic sampling_strobe  // single cycle pulse at the middle of each bit
);

	localparam logic [strobe_cnt_w-1:0] cnt_last = strobe_cnt_w'(clocks_per_bit - 1);
	localparam logic [strobe_cnt_w-1:0] cnt_half = strobe_cnt_w'((clocks_per_bit >> 1) + 1);

	logic [strobe_cnt_w-1:0] counter;  // clocks elapsed in the current bit period

	always_ff @(posedge clk) begin
		if (reset) begin
			counter <= '0;
		end else if (start_detected) begin
			counter <= cnt_half;                       // only half a bit to go until the start bit midpoint
		end else if (counter == cnt_last) begin
			counter <= '0;                             // wraps once per bit period
		end else begin
			counter <= counter + strobe_cnt_w'(1);
		end
	end

	// the strobe is registered so it lands one clock after the counter wraps
	always_ff @(posedge clk) begin
		if (reset) begin
			sampling_strobe <= 1'b0;
		end else begin
			// a wrap that coincides with a new start belongs to the old timing and is dropped
			sampling_strobe <= (counter == cnt_last) && !start_detected;
		end
	end

endmodule

// ==== src/uart_cfg_pkg.sv ====
package uart_cfg_pkg;

	localparam int clocks_per_bit = 16;                 // system clocks in one uart bit, kept short for simulation
	localparam int data_bits = 8;                       // 8n1 frame payload
	localparam int num_channels = 4;                    // receive channels in the array
	localparam int chan_id_w = 2;                       // wide enough to tag any channel

	localparam int strobe_cnt_w = $clog2(clocks_per_bit); // bit period counter width
	localparam int bit_cnt_w = $clog2(data_bits);         // data bit index width

	// receiver states, one step per sampling strobe except hold
	typedef enum logic [2:0] {
		idle,   // waiting for a falling edge on the line
		start,  // checking the start bit at its midpoint
		data,   // shifting data bits lsb first
		stop,   // sampling the stop bit
		hold    // frame ready and waiting for the collector ack
	} rx_state_t;

	// one received frame as stored in the fifo, data sits in the top bits
	typedef struct packed {
		logic [data_bits-1:0] data;        // received byte
		logic                 framing_err; // stop bit was sampled low
		logic [chan_id_w-1:0] chan;        // channel that received the frame
	} rx_frame_t;

endpackage

// ==== src/uart_rx_array.sv ====
`timescale 1ns/1ps

module uart_rx_array import uart_cfg_pkg::*; import apb_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [num_channels-1:0] rx,       // one serial line per channel, idle high
	input  apb_req_t                apb_req,
	output apb_rsp_t                apb_rsp
);

	logic [num_channels-1:0] line;         // synchronized lines to the channels
	logic [num_channels-1:0] start_edge;   // falling edge pulses to the channels
	logic [num_channels-1:0] enable;       // mask from the ctrl register
	logic [num_channels-1:0] frame_valid;
	logic [num_channels-1:0] ack;
	rx_frame_t               frame [num_channels];

	rx_line_sync u_line_sync (
		.clk       (clk),
		.reset     (reset),
		.rx        (rx),
		.enable    (enable),
		.line      (line),
		.start_edge(start_edge)
	);

	for (genvar i = 0; i < num_channels; i++) begin : g_chan
		uart_rx_channel u_channel (
			.clk        (clk),
			.reset      (reset),
			.line       (line[i]),
			.start_edge (start_edge[i]),
			.chan       (chan_id_w'(i)),  // each channel tags frames with its own index
			.ack        (ack[i]),
			.frame      (frame[i]),
			.frame_valid(frame_valid[i])
		);
	end

	rx_collector u_collector (
		.clk        (clk),
		.reset      (reset),
		.frame      (frame),
		.frame_valid(frame_valid),
		.ack        (ack),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.enable     (enable)
	);

endmodule

// ==== src/uart_rx_channel.sv ====
`timescale 1ns/1ps

module uart_rx_channel import uart_cfg_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 line,        // synchronized serial line, idle high
	input  logic                 start_edge,  // falling edge pulse from the sync stage
	input  logic [chan_id_w-1:0] chan,        // channel number stamped into each frame
	input  logic                 ack,         // collector has taken the frame
	output rx_frame_t            frame,       // frame contents, stable while frame_valid is high
	output logic                 frame_valid  // frame waiting for the collector
);

	rx_state_t            state;
	logic                 start_detected;  // start edge accepted by this receiver
	logic                 strobe;          // mid-bit sampling point
	logic [bit_cnt_w-1:0] bit_cnt;         // index of the data bit being shifted
	logic [data_bits-1:0] shift_q;         // data bits collected lsb first
	logic                 ferr_q;          // stop bit was low

	assign start_detected = start_edge && (state == idle);  // edges during a frame are data transitions

	sampling_strobe_generator u_strobe (
		.clk            (clk),
		.reset          (reset),
		.start_detected (start_detected),
		.sampling_strobe(strobe)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (start_detected) state <= start;
				end
				start: begin
					if (strobe) begin
						bit_cnt <= '0;
						state   <= line ? idle : data;  // a high start bit means the edge was a glitch
					end
				end
				data: begin
					if (strobe) begin
						bit_cnt <= bit_cnt + bit_cnt_w'(1);
						if (bit_cnt == bit_cnt_w'(data_bits - 1)) state <= stop;  // last data bit taken
					end
				end
				stop: begin
					if (strobe) state <= hold;    // frame_valid rises in the following cycle
				end
				hold: begin
					if (ack) state <= idle;       // valid drops on the edge after the ack
				end
				default: state <= idle;
			endcase
		end
	end

	// payload registers only move while their bits are being sampled
	always_ff @(posedge clk) begin
		if (state == data && strobe) begin
			shift_q <= {line, shift_q[data_bits-1:1]};  // first bit received ends up in bit 0
		end
		if (state == stop && strobe) begin
			ferr_q <= ~line;                            // stop bit must be high in 8n1
		end
	end

	assign frame_valid = (state == hold);

	assign frame = '{data: shift_q, framing_err: ferr_q, chan: chan};

endmodule
